/* tb.f */
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_writeback.sv
hdl/rv_pipelined_cpu.sv
verification/tb_checker.sv
verification/tb_top.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_top
FILELIST := tb.f
LOG      := sim.log
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/tb_top.sv */
/*
 * Testbench top: clock, reset, instruction and data memory models,
 * program table, test loop and watchdog
 */

`timescale 1ns/1ns

module tb_top;
    import rv_isa_pkg::*;

    localparam int NUM_TESTS  = 6;
    localparam int NUM_SEEDS  = 4;
    localparam int CLK_PERIOD = 4;
    localparam word_t HALT_WORD = 32'hFFFF_FFFF;  // Unknown opcode 7f

    logic  clk;
    logic  reset;
    word_t imem_addr, imem_data;
    word_t dmem_addr, dmem_wdata, dmem_rdata;
    logic  dmem_we;
    logic  halt;
    logic  test_end;
    logic  all_done;
    logic  [7:0] cur_test;
    int    pass_count, fail_count;

    word_t imem [64];
    word_t dmem [64];
    word_t seeds [NUM_SEEDS];
    int    seed;

    // Expected results per test
    word_t exp_addr_tbl [NUM_TESTS];
    word_t exp_data_tbl [NUM_TESTS];
    logic  exp_none_tbl [NUM_TESTS];  // Halt with no store

    // ========================================
    // Program table with eight words per test
    word_t prog_tbl [NUM_TESTS][8] = '{
        // addi, addi, sub, xor, sra chain then sw 64
        '{32'hF9C00093, 32'h00300113, 32'h402081B3, 32'h0021C233,
          32'h402252B3, 32'h04502023, HALT_WORD, HALT_WORD},
        // lw x1 then addi on it at once and sw 68
        '{32'h00002083, 32'h04D08113, 32'h04202223, HALT_WORD,
          HALT_WORD, HALT_WORD, HALT_WORD, HALT_WORD},
        // Taken beq skips x3 = 99 and its store to 72
        '{32'h00B00093, 32'h00B00113, 32'h02A00193, 32'h00208663,
          32'h06300193, 32'h04302423, 32'h04302423, HALT_WORD},
        // blt x0 < -5 falls through then jal x5 link stored at 80
        '{32'hFFB00093, 32'h00104C63, 32'h04102623, 32'h008002EF,
          32'h00100293, 32'h04502823, HALT_WORD, HALT_WORD},
        // lui+addi plus auipc with the sum stored at 84
        '{32'h123450B7, 32'h67808093, 32'h00010117, 32'h002081B3,
          32'h04302A23, HALT_WORD, HALT_WORD, HALT_WORD},
        // Misaligned sw to 66 must halt before the aligned sw to 64
        '{32'h00700093, 32'h04102123, 32'h00000013, 32'h00000013,
          32'h04102023, HALT_WORD, HALT_WORD, HALT_WORD}
    };

    rv_pipelined_cpu u_rv_pipelined_cpu (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .halt       (halt)
    );

    tb_checker u_tb_checker (
        .clk          (clk),
        .reset        (reset),
        .dmem_we      (dmem_we),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .test_end     (test_end),
        .all_done     (all_done),
        .test_id      (cur_test),
        .exp_addr     (exp_addr_tbl[cur_test]),
        .exp_data     (exp_data_tbl[cur_test]),
        .exp_no_store (exp_none_tbl[cur_test]),
        .pass_count   (pass_count),
        .fail_count   (fail_count)
    );

    // Combinational word-addressed reads
    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    // Data memory cleared and seeded in reset with a clocked write
    always @(posedge clk) begin : dmem_model
        int k;
        if (reset) begin
            for (k = 0; k < 64; k++) begin
                dmem[k] <= (k < NUM_SEEDS) ? seeds[k] : '0;
            end
        end else if (dmem_we) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Expected results by the ISA rules from the seeded words
    task automatic build_expect();
        logic signed [31:0] a, b, c, d;
        a = -32'sd100;  // addi x1
        b = 32'sd3;     // addi x2
        c = a - b;
        d = c ^ b;
        exp_addr_tbl = '{32'd64, 32'd68, 32'd72, 32'd80, 32'd84, 32'd66};
        exp_none_tbl = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
        exp_data_tbl[0] = d >>> 3;
        exp_data_tbl[1] = seeds[0] + 32'd77;
        exp_data_tbl[2] = 32'd42;            // Taken path value
        exp_data_tbl[3] = 32'd12 + 32'd4;    // JAL at byte 12
        exp_data_tbl[4] = (32'h12345 << 12) + 32'h678 + 32'd8 + (32'h10 << 12);
        exp_data_tbl[5] = '0;
    endtask

    task automatic run_test(input int idx);
        int k;
        reset    <= 1'b1;
        cur_test <= 8'(idx);
        for (k = 0; k < 64; k++) begin
            imem[k] <= (k < 8) ? prog_tbl[idx][k] : HALT_WORD;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        do @(posedge clk); while (!halt);
        test_end <= 1'b1;                   // Checker samples next edge
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    // ========================================
    // Test loop
    initial begin
        reset    = 1'b1;
        test_end = 1'b0;
        all_done = 1'b0;
        cur_test = '0;
        seed     = 95503;
        for (int k = 0; k < NUM_SEEDS; k++) begin
            seeds[k] = $random(seed);
        end
        build_expect();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        all_done <= 1'b1;
        @(posedge clk);
        all_done <= 1'b0;
        @(posedge clk);
        if (fail_count == 0 && pass_count == NUM_TESTS) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog allows 100 cycles per test
    initial begin
        #(NUM_TESTS * 100 * CLK_PERIOD);
        $display("Run timed out before all tests reached halt");
        $display("test failed");
        $finish;
    end

endmodule

/* verification/tb_checker.sv */
/*
 * Result checker: records the last data-memory write of a test,
 * compares it at test end, keeps pass and fail counts
 */

`timescale 1ns/1ns

module tb_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic                dmem_we,
    input  rv_isa_pkg::word_t   dmem_addr,
    input  rv_isa_pkg::word_t   dmem_wdata,
    input  logic                test_end,     // One-cycle strobe after halt
    input  logic                all_done,
    input  logic [7:0]          test_id,
    input  rv_isa_pkg::word_t   exp_addr,
    input  rv_isa_pkg::word_t   exp_data,
    input  logic                exp_no_store,
    output int                  pass_count,
    output int                  fail_count
);
    import rv_isa_pkg::*;

    logic  seen_write;
    word_t last_addr;
    word_t last_data;

    initial begin
        pass_count = 0;
        fail_count = 0;
    end

    // ========================================
    // Write capture and end-of-test compare
    always @(posedge clk) begin : watch
        logic ok;
        ok = 1'b1;
        if (reset) begin
            seen_write <= 1'b0;
            last_addr  <= '0;
            last_data  <= '0;
        end else if (dmem_we) begin
            seen_write <= 1'b1;                // Latest store wins
            last_addr  <= dmem_addr;
            last_data  <= dmem_wdata;
        end
        if (test_end) begin
            if (exp_no_store) begin
                if (seen_write) begin
                    $display("Test %0d wrote data memory at %h though the store was misaligned",
                             test_id, last_addr);
                    ok = 1'b0;
                end
            end else if (!seen_write) begin
                $display("Test %0d halted without writing data memory", test_id);
                ok = 1'b0;
            end else begin
                if (last_addr !== exp_addr) begin
                    $display("CHECK FAILED at %0t: dmem_addr got %h expected %h",
                             $time, last_addr, exp_addr);
                    ok = 1'b0;
                end
                if (last_data !== exp_data) begin
                    $display("CHECK FAILED at %0t: dmem_wdata got %h expected %h",
                             $time, last_data, exp_data);
                    ok = 1'b0;
                end
            end
            if (ok) begin
                pass_count <= pass_count + 1;
                $display("Test %0d: ok", test_id);
            end else begin
                fail_count <= fail_count + 1;
                $display("Test %0d: FAILED", test_id);
            end
        end
        if (all_done) begin
            $display("Tests done: %0d ok, %0d failed", pass_count, fail_count);
        end
    end

endmodule

/* hdl/rv_pipelined_cpu.sv */
/*
 * Five-stage RV32I core top level: wires fetch, decode,
 * execute and memory/writeback to the instruction and data ports
 */

`timescale 1ns/1ns

module rv_pipelined_cpu (
    input  logic              clk,
    input  logic              reset,
    output rv_isa_pkg::word_t imem_addr,
    input  rv_isa_pkg::word_t imem_data,
    output rv_isa_pkg::word_t dmem_addr,
    output rv_isa_pkg::word_t dmem_wdata,
    output logic              dmem_we,
    input  rv_isa_pkg::word_t dmem_rdata,
    output logic              halt
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    // ========================================
    // Stage links
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;

    // Back-links
    logic    stall;            // Load-use, from decode
    logic    branch_taken;     // Redirect and flush, from execute
    word_t   branch_target;
    fwd_t    mem_fwd;          // EX/MEM forwarding source
    fwd_t    wb_fwd;           // MEM/WB source and RF write

    rv_fetch u_rv_fetch (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .if_id         (if_id)
    );

    rv_decode u_rv_decode (
        .clk          (clk),
        .reset        (reset),
        .if_id        (if_id),
        .branch_taken (branch_taken),
        .wb_fwd       (wb_fwd),
        .stall        (stall),
        .id_ex        (id_ex)
    );

    rv_execute u_rv_execute (
        .clk           (clk),
        .reset         (reset),
        .id_ex         (id_ex),
        .mem_fwd       (mem_fwd),
        .wb_fwd        (wb_fwd),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .ex_mem        (ex_mem)
    );

    rv_writeback u_rv_writeback (
        .clk        (clk),
        .reset      (reset),
        .ex_mem     (ex_mem),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .halt       (halt)
    );

endmodule

/* hdl/rv_writeback.sv */
/*
 * Memory and writeback: alignment check, data port,
 * MEM/WB register, writeback select, forwarding sources, halt
 */

`timescale 1ns/1ns

module rv_writeback (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_pipe_pkg::ex_mem_t ex_mem,
    output rv_isa_pkg::word_t    dmem_addr,
    output rv_isa_pkg::word_t    dmem_wdata,
    output logic                 dmem_we,
    input  rv_isa_pkg::word_t    dmem_rdata,
    output rv_pipe_pkg::fwd_t    mem_fwd,
    output rv_pipe_pkg::fwd_t    wb_fwd,
    output logic                 halt
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic    misaligned;
    mem_wb_t mem_wb;
    word_t   wb_data;

    // Word accesses only
    assign misaligned = (ex_mem.mem_read || ex_mem.mem_write) && (ex_mem.alu_result[1:0] != 2'b00);

    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.mem_write && !misaligned;   // Bad store never lands

    // Load data not ready yet, so a load is not a MEM source
    assign mem_fwd = '{rd: ex_mem.rd, data: ex_mem.alu_result,
                       reg_write: ex_mem.reg_write && !ex_mem.mem_read};

    // ========================================
    // MEM/WB register
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb <= '0;
        end else begin
            mem_wb.read_data  <= dmem_rdata;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.rd         <= ex_mem.rd;
            mem_wb.reg_write  <= ex_mem.reg_write && !misaligned;
            mem_wb.mem_to_reg <= ex_mem.mem_read;
            mem_wb.halt       <= ex_mem.is_halt || misaligned;
        end
    end

    assign wb_data = mem_wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_result;
    assign wb_fwd  = '{rd: mem_wb.rd, data: wb_data, reg_write: mem_wb.reg_write};
    assign halt    = mem_wb.halt;      // Held while the entry sits in WB

endmodule

/* hdl/rv_execute.sv */
/*
 * Execute stage: operand forwarding, ALU input select, ALU,
 * branch and jump resolution, EX/MEM register
 */

`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_execute (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_pipe_pkg::id_ex_t  id_ex,
    input  rv_pipe_pkg::fwd_t    mem_fwd,     // From EX/MEM
    input  rv_pipe_pkg::fwd_t    wb_fwd,      // From MEM/WB
    output logic                 branch_taken,
    output rv_isa_pkg::word_t    branch_target,
    output rv_pipe_pkg::ex_mem_t ex_mem
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t   op_a, op_b;                   // Forwarded register operands
    word_t   alu_a, alu_b;
    word_t   alu_result;
    word_t   target_base;
    logic    cond_met;
    ex_mem_t ex_mem_next;

    // Youngest producer wins; x0 is never forwarded
    function automatic word_t fwd_pick(reg_idx_t idx, word_t rf_val, fwd_t mem, fwd_t wb);
        if (idx == '0) begin
            return rf_val;
        end
        if (mem.reg_write && mem.rd == idx) begin
            return mem.data;
        end
        if (wb.reg_write && wb.rd == idx) begin
            return wb.data;
        end
        return rf_val;
    endfunction

    assign op_a = fwd_pick(id_ex.rs1, id_ex.rs1_data, mem_fwd, wb_fwd);
    assign op_b = fwd_pick(id_ex.rs2, id_ex.rs2_data, mem_fwd, wb_fwd);

    // ========================================
    // ALU operands
    always_comb begin
        case (id_ex.opcode)
            op_auipc, op_jal, op_jalr: alu_a = id_ex.pc;
            op_lui:                    alu_a = '0;
            default:                   alu_a = op_a;
        endcase
    end

    assign alu_b = id_ex.ctrl.is_jump ? word_t'(`RV_PC_STEP) :   // Link address
                   id_ex.ctrl.use_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            alu_add:  alu_result = alu_a + alu_b;
            alu_sub:  alu_result = alu_a - alu_b;
            alu_sll:  alu_result = alu_a << alu_b[4:0];
            alu_slt:  alu_result = word_t'($signed(alu_a) < $signed(alu_b));
            alu_sltu: alu_result = word_t'(alu_a < alu_b);
            alu_xor:  alu_result = alu_a ^ alu_b;
            alu_srl:  alu_result = alu_a >> alu_b[4:0];
            alu_sra:  alu_result = word_t'($signed(alu_a) >>> alu_b[4:0]);
            alu_or:   alu_result = alu_a | alu_b;
            default:  alu_result = alu_a & alu_b;
        endcase
    end

    // ========================================
    // Branch resolution on forwarded operands
    always_comb begin
        case (id_ex.funct3)
            f3_beq:  cond_met = (op_a == op_b);
            f3_bne:  cond_met = (op_a != op_b);
            f3_blt:  cond_met = ($signed(op_a) <  $signed(op_b));
            f3_bge:  cond_met = ($signed(op_a) >= $signed(op_b));
            f3_bltu: cond_met = (op_a <  op_b);
            f3_bgeu: cond_met = (op_a >= op_b);
            default: cond_met = 1'b0;
        endcase
    end

    assign branch_taken  = (id_ex.ctrl.is_branch && cond_met) || id_ex.ctrl.is_jump;
    assign target_base   = (id_ex.opcode == op_jalr) ? op_a : id_ex.pc;
    assign branch_target = (target_base + id_ex.imm) & ~word_t'(1);  // JALR clears bit 0

    always_comb begin
        ex_mem_next.alu_result = alu_result;
        ex_mem_next.store_data = op_b;
        ex_mem_next.rd         = id_ex.rd;
        ex_mem_next.reg_write  = id_ex.ctrl.reg_write;
        ex_mem_next.mem_write  = id_ex.ctrl.mem_write;
        ex_mem_next.mem_read   = id_ex.ctrl.mem_read;
        ex_mem_next.is_halt    = id_ex.ctrl.is_halt;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_mem_next;
        end
    end

endmodule

/* hdl/rv_decode.sv */
/*
 * Decode stage: control and ALU-op decode, immediates,
 * register file with WB bypass, load-use stall, ID/EX register
 */

`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_decode (
    input  logic                clk,
    input  logic                reset,
    input  rv_pipe_pkg::if_id_t if_id,
    input  logic                branch_taken,
    input  rv_pipe_pkg::fwd_t   wb_fwd,    // Register file write port
    output logic                stall,
    output rv_pipe_pkg::id_ex_t id_ex
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t    instr;
    opcode_e  opcode;
    reg_idx_t rs1, rs2, rd;
    funct3_t  funct3;
    logic     funct7_bit;                  // Only bit 30 matters
    ctrl_t    ctrl;
    alu_op_e  alu_op;
    word_t    imm;
    word_t    rs1_data, rs2_data;
    word_t    regs [`RV_NUM_REGS];
    id_ex_t   id_ex_next;

    assign instr      = if_id.instr;
    assign opcode     = opcode_e'(instr[6:0]);
    assign rd         = instr[11:7];
    assign funct3     = instr[14:12];
    assign rs1        = instr[19:15];
    assign rs2        = instr[24:20];
    assign funct7_bit = instr[30];

    // Sub and sra only on R-type; srai keeps bit 30 in its immediate
    function automatic alu_op_e alu_select(funct3_t f3, logic alt, logic is_reg);
        case (f3)
            f3_add_sub: return (alt && is_reg) ? alu_sub : alu_add;
            f3_sll:     return alu_sll;
            f3_slt:     return alu_slt;
            f3_sltu:    return alu_sltu;
            f3_xor:     return alu_xor;
            f3_srl_sra: return alt ? alu_sra : alu_srl;
            f3_or:      return alu_or;
            default:    return alu_and;
        endcase
    endfunction

    // ========================================
    // Control decode
    always_comb begin
        ctrl   = '0;
        alu_op = alu_add;                  // Address and link math
        case (opcode)
            op_compute: begin
                ctrl.reg_write = 1'b1;
                alu_op         = alu_select(funct3, funct7_bit, 1'b1);
            end
            op_compute_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                alu_op         = alu_select(funct3, funct7_bit, 1'b0);
            end
            op_load:          {ctrl.reg_write, ctrl.mem_read, ctrl.use_imm} = 3'b111;
            op_store:         {ctrl.mem_write, ctrl.use_imm} = 2'b11;
            op_branch:        ctrl.is_branch = 1'b1;
            op_lui, op_auipc: {ctrl.reg_write, ctrl.use_imm} = 2'b11;
            op_jal, op_jalr:  {ctrl.reg_write, ctrl.is_jump} = 2'b11;
            default:          ctrl.is_halt = (instr != '0); // All-zero word is a bubble
        endcase
    end

    // Immediate formats
    always_comb begin
        case (opcode)
            op_store:         imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            op_branch:        imm = {{19{instr[31]}}, instr[31], instr[7],
                                     instr[30:25], instr[11:8], 1'b0};
            op_lui, op_auipc: imm = {instr[31:12], 12'b0};
            op_jal:           imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                     instr[20], instr[30:21], 1'b0};
            default:          imm = {{20{instr[31]}}, instr[31:20]}; // I-type
        endcase
    end

    // ========================================
    // Register file, x0 never written
    always_ff @(posedge clk) begin
        if (wb_fwd.reg_write && wb_fwd.rd != '0) begin
            regs[wb_fwd.rd] <= wb_fwd.data;
        end
    end

    // Same-cycle WB write bypasses to the read
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wb_fwd.reg_write && wb_fwd.rd == rs1) ? wb_fwd.data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wb_fwd.reg_write && wb_fwd.rd == rs2) ? wb_fwd.data : regs[rs2];

    // Load in EX feeding this instruction
    assign stall = id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                   ((id_ex.rd == rs1) || (id_ex.rd == rs2));

    always_comb begin
        id_ex_next.pc       = if_id.pc;
        id_ex_next.rs1_data = rs1_data;
        id_ex_next.rs2_data = rs2_data;
        id_ex_next.imm      = imm;
        id_ex_next.rs1      = rs1;
        id_ex_next.rs2      = rs2;
        id_ex_next.rd       = rd;
        id_ex_next.opcode   = opcode;
        id_ex_next.funct3   = funct3;
        id_ex_next.alu_op   = alu_op;
        id_ex_next.ctrl     = ctrl;
    end

    // ID/EX register, bubble on stall or flush
    always_ff @(posedge clk) begin
        if (reset || stall || branch_taken) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_next;
        end
    end

endmodule

/* hdl/rv_fetch.sv */
/*
 * Fetch stage: PC register, next-PC select, IF/ID register
 */

`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_fetch (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,         // Load-use hold
    input  logic                branch_taken,
    input  rv_isa_pkg::word_t   branch_target,
    output rv_isa_pkg::word_t   imem_addr,
    input  rv_isa_pkg::word_t   imem_data,
    output rv_pipe_pkg::if_id_t if_id
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t pc;
    word_t pc_next;

    // Redirect wins over sequential advance
    assign pc_next   = branch_taken ? branch_target : pc + word_t'(`RV_PC_STEP);
    assign imem_addr = pc;                 // Combinational instruction read

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else if (branch_taken || !stall) begin
            pc <= pc_next;
        end
    end

    // ========================================
    // IF/ID register
    always_ff @(posedge clk) begin
        if (reset || branch_taken) begin
            if_id <= '0;                   // Squash wrong-path fetch
        end else if (!stall) begin
            if_id.pc    <= pc;
            if_id.instr <= imem_data;
        end
    end

endmodule

/* hdl/rv_pipe_pkg.sv */
/*
 * Pipeline types: control bundle, ALU operation enum,
 * the four stage-register structs and the forwarding source
 */

package rv_pipe_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    // Decoded control, 7 bits
    typedef struct packed {
        logic reg_write;
        logic mem_write;
        logic mem_read;
        logic use_imm;   // ALU B from immediate
        logic is_branch;
        logic is_jump;   // JAL or JALR
        logic is_halt;   // Unknown non-zero opcode
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t    pc;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        opcode_e  opcode;
        funct3_t  funct3;
        alu_op_e  alu_op;
        ctrl_t    ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t    alu_result; // Also the data address
        word_t    store_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_write;
        logic     mem_read;
        logic     is_halt;
    } ex_mem_t;

    typedef struct packed {
        word_t    read_data;
        word_t    alu_result;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_to_reg;
        logic     halt;       // Halt opcode or misaligned access
    } mem_wb_t;

    // One forwarding source, 38 bits
    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
        logic     reg_write;
    } fwd_t;

endpackage

/* hdl/rv_isa_pkg.sv */
/*
 * RV32I instruction-set types: word, register index,
 * opcode enum and the funct3 codes for ALU and branches
 */

`include "rv_defines.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;    // Data or address word
    typedef logic [4:0]          reg_idx_t; // x0..x31
    typedef logic [2:0]          funct3_t;

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_compute     = 7'b0110011, // R-type
        op_compute_imm = 7'b0010011, // I-type arithmetic
        op_branch      = 7'b1100011,
        op_load        = 7'b0000011,
        op_store       = 7'b0100011,
        op_lui         = 7'b0110111,
        op_auipc       = 7'b0010111,
        op_jal         = 7'b1101111,
        op_jalr        = 7'b1100111
    } opcode_e;

    // ========================================
    // ALU funct3
    localparam funct3_t f3_add_sub = 3'b000; // Bit 30 picks sub on R-type
    localparam funct3_t f3_sll     = 3'b001;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_sltu    = 3'b011;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_srl_sra = 3'b101; // Bit 30 picks arithmetic
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;

    // ========================================
    // Branch conditions
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

endpackage

/* hdl/rv_defines.svh */
/*
 * Core-wide size and reset macros:
 * data width, register count, reset PC, PC increment
 */

`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Datapath width in bits
`define RV_XLEN 32

// Architectural integer registers, x0 included
`define RV_NUM_REGS 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Sequential PC advance, also the link offset
`define RV_PC_STEP 4

`endif
